/* source/dbg_pkg.sv */
package dbg_pkg;

    // Widths with a meaning on the debug path
    typedef logic [33:0] dbg_word_t;   // Subtype in 33:32, payload in 31:0
    typedef logic [1:0]  dbg_sub_t;
    typedef logic [29:0] wb_addr_t;    // Word address, no byte lanes
    typedef logic [31:0] wb_data_t;
    typedef logic [7:0]  byte_t;

    // Command subtypes from the host
    localparam dbg_sub_t CMD_SUB_RD      = 2'd0;
    localparam dbg_sub_t CMD_SUB_WR      = 2'd1;
    localparam dbg_sub_t CMD_SUB_ADDR    = 2'd2;
    localparam dbg_sub_t CMD_SUB_SPECIAL = 2'd3;  // Decoded, no action

    // Response subtypes back to the host
    localparam dbg_sub_t RSP_SUB_DATA    = 2'd0;
    localparam dbg_sub_t RSP_SUB_ACK     = 2'd1;
    localparam dbg_sub_t RSP_SUB_ADDR    = 2'd2;
    localparam dbg_sub_t RSP_SUB_SPECIAL = 2'd3;

    // Special response codes, payload bits 31:29
    localparam logic [2:0] RSP_CODE_RESET     = 3'd0;
    localparam logic [2:0] RSP_CODE_BUS_ERROR = 3'd1;

    // Bytes per word on either byte channel
    localparam int WORD_BYTES = 5;

endpackage

/* source/cmd_assembler.sv */
`timescale 1ns/1ps

module cmd_assembler (
    input  logic              i_clk,
    input  logic              i_reset,
    // Byte channel from the host
    input  logic              i_rx_req,
    input  dbg_pkg::byte_t    i_rx_byte,
    output logic              o_rx_ack,
    // Command word to the master
    output logic              o_cmd_stb,
    output dbg_pkg::dbg_word_t o_cmd_word,
    input  logic              i_cmd_busy
);

    // Handshake phase of the current byte
    typedef enum logic {
        RX_IDLE,    // Waiting for req
        RX_ACK      // Ack up, waiting for req to drop
    } rx_state_t;

    rx_state_t  rx_state;
    logic [2:0] byte_cnt;      // Bytes gathered so far
    logic       word_full;     // Five bytes in, strobe not yet up
    logic       rx_take;       // Byte accepted this cycle

    assign word_full = (byte_cnt == 3'(dbg_pkg::WORD_BYTES));

    // No new byte while a finished word waits for the master
    assign rx_take = (rx_state == RX_IDLE) && i_rx_req && !word_full && !o_cmd_stb;

    assign o_rx_ack = (rx_state == RX_ACK);

    // Four-phase receive side
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rx_state <= RX_IDLE;
        end else begin
            case (rx_state)
                RX_IDLE: begin
                    if (rx_take)
                        rx_state <= RX_ACK;   // Ack one cycle after req
                end
                RX_ACK: begin
                    if (!i_rx_req)
                        rx_state <= RX_IDLE;  // Ack drops after req
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    // Byte count and strobe toward the master
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            byte_cnt  <= '0;
            o_cmd_stb <= 1'b0;
        end else begin
            if (word_full) begin
                o_cmd_stb <= 1'b1;            // One cycle after fifth ack
                byte_cnt  <= '0;
            end else if (rx_take) begin
                byte_cnt <= byte_cnt + 3'd1;
            end

            if (o_cmd_stb && !i_cmd_busy)
                o_cmd_stb <= 1'b0;            // Taken by master
        end
    end

    // Byte 0 first, so it ends up in the subtype bits
    always_ff @(posedge i_clk) begin
        if (rx_take)
            o_cmd_word <= {o_cmd_word[25:0], i_rx_byte};
    end

endmodule

/* source/wb_master.sv */
`timescale 1ns/1ps

module wb_master (
    input  logic                i_clk,
    input  logic                i_reset,
    // Command path
    input  logic                i_cmd_stb,
    input  dbg_pkg::dbg_word_t  i_cmd_word,
    output logic                o_cmd_busy,
    // Response path
    output logic                o_rsp_stb,
    output dbg_pkg::dbg_word_t  o_rsp_word,
    input  logic                i_rsp_busy,
    // Wishbone master
    output logic                o_wb_cyc,
    output logic                o_wb_stb,
    output logic                o_wb_we,
    output dbg_pkg::wb_addr_t   o_wb_addr,
    output dbg_pkg::wb_data_t   o_wb_data,
    input  logic                i_wb_stall,
    input  logic                i_wb_ack,
    input  logic                i_wb_err,
    input  dbg_pkg::wb_data_t   i_wb_data
);

    dbg_pkg::dbg_sub_t cmd_sub;
    logic cmd_take;       // Command word accepted this cycle
    logic cmd_bus;        // Read or write
    logic cmd_addr;       // Address set
    logic bus_done;       // Ack or err ends the transfer
    logic addr_fixed;     // No increment after a strobe
    logic rsp_pend;       // Response waiting for the serializer
    logic rsp_event;
    logic rsp_ready;

    assign cmd_sub  = i_cmd_word[33:32];
    assign cmd_take = i_cmd_stb && !o_cmd_busy;
    assign cmd_bus  = cmd_take && !cmd_sub[1];   // Bit 33 clear means bus command
    assign cmd_addr = cmd_take && (cmd_sub == dbg_pkg::CMD_SUB_ADDR);
    assign bus_done = o_wb_cyc && (i_wb_ack || i_wb_err);

    // One thing at a time, including the response going out
    assign o_cmd_busy = o_wb_cyc || rsp_pend || o_rsp_stb || i_rsp_busy;

    // Bus cycle control
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
        end else if (o_wb_cyc && i_wb_err) begin
            o_wb_cyc <= 1'b0;                 // Error aborts at once
            o_wb_stb <= 1'b0;
        end else if (o_wb_cyc) begin
            if (o_wb_stb && !i_wb_stall)
                o_wb_stb <= 1'b0;             // Single request only
            if (i_wb_ack)
                o_wb_cyc <= 1'b0;
        end else if (cmd_bus) begin
            o_wb_cyc <= 1'b1;
            o_wb_stb <= 1'b1;
        end
    end

    // Direction and write data latched with the command
    always_ff @(posedge i_clk) begin
        if (cmd_bus) begin
            o_wb_we   <= (cmd_sub == dbg_pkg::CMD_SUB_WR);
            o_wb_data <= i_cmd_word[31:0];
        end
    end

    // Address register and increment mode
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_addr  <= '0;
            addr_fixed <= 1'b0;
        end else if (cmd_addr) begin
            o_wb_addr  <= i_cmd_word[29:0];
            addr_fixed <= i_cmd_word[30];
        end else if (o_wb_stb && !i_wb_stall && !addr_fixed) begin
            o_wb_addr <= o_wb_addr + 30'd1;   // Step after acceptance
        end
    end

    assign rsp_event = bus_done || cmd_addr;
    assign rsp_ready = rsp_event || rsp_pend;

    // Response word, loaded when its event happens
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rsp_word <= {dbg_pkg::RSP_SUB_SPECIAL, dbg_pkg::RSP_CODE_RESET, 29'd0};
        end else if (bus_done) begin
            if (i_wb_err)
                o_rsp_word <= {dbg_pkg::RSP_SUB_SPECIAL, dbg_pkg::RSP_CODE_BUS_ERROR, 29'd0};
            else if (o_wb_we)
                o_rsp_word <= {dbg_pkg::RSP_SUB_ACK, 32'd0};
            else
                o_rsp_word <= {dbg_pkg::RSP_SUB_DATA, i_wb_data};
        end else if (cmd_addr) begin
            // Echo of the new address and its mode
            o_rsp_word <= {dbg_pkg::RSP_SUB_ADDR, 1'b0, i_cmd_word[30], i_cmd_word[29:0]};
        end
    end

    // Strobe only toward an idle serializer
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rsp_stb <= 1'b0;
            rsp_pend  <= 1'b1;                // Reset notice goes out first
        end else if (rsp_ready && !i_rsp_busy && !o_rsp_stb) begin
            o_rsp_stb <= 1'b1;
            rsp_pend  <= 1'b0;
        end else begin
            o_rsp_stb <= 1'b0;
            rsp_pend  <= rsp_ready;
        end
    end

    // Request only inside a cycle
    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb_stb |-> o_wb_cyc);

    // Serializer must be free when a response is offered
    a_rsp_no_overrun: assert property (@(posedge i_clk) disable iff (i_reset)
        o_rsp_stb |-> !i_rsp_busy);

endmodule

/* source/rsp_serializer.sv */
`timescale 1ns/1ps

module rsp_serializer (
    input  logic                i_clk,
    input  logic                i_reset,
    // Response word from the master
    input  logic                i_rsp_stb,
    input  dbg_pkg::dbg_word_t  i_rsp_word,
    output logic                o_rsp_busy,
    // Byte channel to the host
    output logic                o_tx_req,
    output dbg_pkg::byte_t      o_tx_byte,
    input  logic                i_tx_ack
);

    typedef enum logic [1:0] {
        TX_IDLE,      // No word held
        TX_REQ,       // Req up, waiting for ack
        TX_REL        // Req down, waiting for ack to drop
    } tx_state_t;

    tx_state_t          tx_state;
    dbg_pkg::dbg_word_t tx_word;     // Word being sent
    logic [2:0]         byte_idx;    // 0 is the subtype byte

    assign o_rsp_busy = (tx_state != TX_IDLE);
    assign o_tx_req   = (tx_state == TX_REQ);

    // Byte select, payload most significant first
    always_comb begin
        case (byte_idx)
            3'd0:    o_tx_byte = {6'd0, tx_word[33:32]};
            3'd1:    o_tx_byte = tx_word[31:24];
            3'd2:    o_tx_byte = tx_word[23:16];
            3'd3:    o_tx_byte = tx_word[15:8];
            default: o_tx_byte = tx_word[7:0];
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (tx_state == TX_IDLE && i_rsp_stb)
            tx_word <= i_rsp_word;            // Capture even if ack lingers
    end

    // Four phases per byte, five bytes per word
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            tx_state <= TX_IDLE;
            byte_idx <= '0;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    byte_idx <= '0;
                    if (i_rsp_stb)
                        tx_state <= TX_REQ;   // First req next cycle
                end
                TX_REQ: begin
                    if (i_tx_ack)
                        tx_state <= TX_REL;
                end
                TX_REL: begin
                    if (!i_tx_ack) begin
                        if (byte_idx == 3'(dbg_pkg::WORD_BYTES - 1)) begin
                            tx_state <= TX_IDLE;  // Last ack gone, free again
                        end else begin
                            byte_idx <= byte_idx + 3'd1;
                            tx_state <= TX_REQ;
                        end
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    // Host sees a steady byte for the whole request
    a_tx_byte_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_tx_req && $past(o_tx_req) |-> $stable(o_tx_byte));

endmodule

/* source/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram #(
    parameter int RAM_AW = 8          // Word address bits
) (
    input  logic               i_clk,
    input  logic               i_reset,
    // Wishbone pipelined slave
    input  logic               i_wb_cyc,
    input  logic               i_wb_stb,
    input  logic               i_wb_we,
    input  dbg_pkg::wb_addr_t  i_wb_addr,
    input  dbg_pkg::wb_data_t  i_wb_data,
    output logic               o_wb_stall,
    output logic               o_wb_ack,
    output logic               o_wb_err,
    output dbg_pkg::wb_data_t  o_wb_data
);

    localparam int DEPTH = 2 ** RAM_AW;

    dbg_pkg::wb_data_t mem [DEPTH];

    logic              req_take;     // Request accepted this cycle
    logic              in_range;     // Upper address bits all zero
    logic [RAM_AW-1:0] ram_idx;

    assign ram_idx  = i_wb_addr[RAM_AW-1:0];
    assign in_range = ((i_wb_addr >> RAM_AW) == '0);

    // Busy while the answer is on the bus
    assign o_wb_stall = o_wb_ack || o_wb_err;
    assign req_take   = i_wb_cyc && i_wb_stb && !o_wb_stall;

    // Ack or err one cycle after acceptance
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
        end else begin
            o_wb_ack <= req_take && in_range;
            o_wb_err <= req_take && !in_range;
        end
    end

    // Word array, full four lanes only
    always_ff @(posedge i_clk) begin
        if (req_take && in_range && i_wb_we)
            mem[ram_idx] <= i_wb_data;
    end

    // Read data with the ack, old contents on a write
    always_ff @(posedge i_clk) begin
        if (req_take && in_range)
            o_wb_data <= mem[ram_idx];
    end

endmodule

/* source/dbg_bus_top.sv */
`timescale 1ns/1ps

module dbg_bus_top #(
    parameter int RAM_AW = 8
) (
    input  logic           i_clk,
    input  logic           i_reset,
    // Host command bytes
    input  logic           i_rx_req,
    input  dbg_pkg::byte_t i_rx_byte,
    output logic           o_rx_ack,
    // Host response bytes
    output logic           o_tx_req,
    output dbg_pkg::byte_t o_tx_byte,
    input  logic           i_tx_ack
);

    // Command path
    logic               cmd_stb;
    dbg_pkg::dbg_word_t cmd_word;
    logic               cmd_busy;

    // Response path
    logic               rsp_stb;
    dbg_pkg::dbg_word_t rsp_word;
    logic               rsp_busy;

    // Wishbone between master and RAM
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    dbg_pkg::wb_addr_t  wb_addr;
    dbg_pkg::wb_data_t  wb_wdata;
    logic               wb_stall;
    logic               wb_ack;
    logic               wb_err;
    dbg_pkg::wb_data_t  wb_rdata;

    cmd_assembler u_cmd_assembler (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_req   (i_rx_req),
        .i_rx_byte  (i_rx_byte),
        .o_rx_ack   (o_rx_ack),
        .o_cmd_stb  (cmd_stb),
        .o_cmd_word (cmd_word),
        .i_cmd_busy (cmd_busy)
    );

    wb_master u_wb_master (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_cmd_stb  (cmd_stb),
        .i_cmd_word (cmd_word),
        .o_cmd_busy (cmd_busy),
        .o_rsp_stb  (rsp_stb),
        .o_rsp_word (rsp_word),
        .i_rsp_busy (rsp_busy),
        .o_wb_cyc   (wb_cyc),
        .o_wb_stb   (wb_stb),
        .o_wb_we    (wb_we),
        .o_wb_addr  (wb_addr),
        .o_wb_data  (wb_wdata),
        .i_wb_stall (wb_stall),
        .i_wb_ack   (wb_ack),
        .i_wb_err   (wb_err),
        .i_wb_data  (wb_rdata)
    );

    rsp_serializer u_rsp_serializer (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rsp_stb  (rsp_stb),
        .i_rsp_word (rsp_word),
        .o_rsp_busy (rsp_busy),
        .o_tx_req   (o_tx_req),
        .o_tx_byte  (o_tx_byte),
        .i_tx_ack   (i_tx_ack)
    );

    wb_ram #(
        .RAM_AW (RAM_AW)
    ) u_wb_ram (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_we    (wb_we),
        .i_wb_addr  (wb_addr),
        .i_wb_data  (wb_wdata),
        .o_wb_stall (wb_stall),
        .o_wb_ack   (wb_ack),
        .o_wb_err   (wb_err),
        .o_wb_data  (wb_rdata)
    );

endmodule

/* verif/dbg_bus_tb.sv */
`timescale 1ns/1ps

module dbg_bus_tb;

    localparam int RESET_CYCLES = 5;
    localparam int TEST_CYCLES  = 200;    // Budget per command and response

    logic       i_clk;
    logic       i_reset;
    logic       i_rx_req;
    logic [7:0] i_rx_byte;
    logic       o_rx_ack;
    logic       o_tx_req;
    logic [7:0] o_tx_byte;
    logic       i_tx_ack;

    // Tests from the data file
    logic [8*24-1:0] test_name [$];
    logic [33:0]     test_cmd [$];
    logic [33:0]     test_exp [$];
    int              num_tests;
    logic            load_done;

    dbg_bus_top #(
        .RAM_AW (8)
    ) uut (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_rx_req  (i_rx_req),
        .i_rx_byte (i_rx_byte),
        .o_rx_ack  (o_rx_ack),
        .o_tx_req  (o_tx_req),
        .o_tx_byte (o_tx_byte),
        .i_tx_ack  (i_tx_ack)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;    // 10 ns period
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Step to 1 ns past the next rising edge
    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic random_wait();
        int unsigned n;
        n = $urandom % 4;             // 0 to 3 cycles
        repeat (n) next_cycle();
    endtask

    // Host side of one four-phase byte into the bridge
    task automatic send_byte(input logic [7:0] b);
        random_wait();
        i_rx_req  = 1'b1;
        i_rx_byte = b;
        next_cycle();
        while (!o_rx_ack) next_cycle();
        i_rx_req = 1'b0;
        while (o_rx_ack) next_cycle();    // Ack drops after req
    endtask

    // Subtype byte first, then payload MSB first
    task automatic send_word(input logic [33:0] w);
        send_byte({6'd0, w[33:32]});
        send_byte(w[31:24]);
        send_byte(w[23:16]);
        send_byte(w[15:8]);
        send_byte(w[7:0]);
    endtask

    // Host side of five bytes out of the bridge
    task automatic receive_word(output logic [33:0] w);
        logic [7:0] b;
        int         i;
        w = '0;
        for (i = 0; i < 5; i++) begin
            while (!o_tx_req) next_cycle();
            random_wait();
            b = o_tx_byte;                // Req still high here
            if (i == 0) begin
                assert (b[7:2] == 6'd0) else
                    stop_with_error("Response subtype byte has nonzero upper bits");
                w[33:32] = b[1:0];
            end else begin
                w[31:0] = {w[23:0], b};
            end
            i_tx_ack = 1'b1;
            while (o_tx_req) next_cycle();
            random_wait();
            i_tx_ack = 1'b0;
        end
    endtask

    task automatic check_word(input logic [8*24-1:0] name, input logic [33:0] exp,
                              input logic [33:0] got);
        assert (got === exp) else
            stop_with_error($sformatf("FAILED %0s: expected %09h, actual %09h",
                                      name, exp, got));
    endtask

    // Name, command word, expected response per line
    task automatic load_tests();
        int               fd;
        int               cnt;
        logic [8*128-1:0] line;
        logic [8*24-1:0]  name;
        logic [33:0]      cmd;
        logic [33:0]      exp;
        fd = $fopen("verif/dbg_bus_tests.txt", "r");
        if (fd == 0)
            stop_with_error("Cannot open the test data file verif/dbg_bus_tests.txt");
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                cnt = $sscanf(line, "%s %h %h", name, cmd, exp);
                if (cnt == 3) begin       // Comments and blank lines drop out
                    test_name.push_back(name);
                    test_cmd.push_back(cmd);
                    test_exp.push_back(exp);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        logic [33:0] got;
        int          t;
        i_reset   = 1'b1;
        i_rx_req  = 1'b0;
        i_rx_byte = 8'd0;
        i_tx_ack  = 1'b0;
        load_done = 1'b0;
        void'($urandom(45));
        load_tests();
        num_tests = test_cmd.size();
        if (num_tests == 0)
            stop_with_error("The test data file holds no tests");
        load_done = 1'b1;

        repeat (RESET_CYCLES) next_cycle();
        i_reset = 1'b0;

        // Special subtype with the reset code, rest zero
        receive_word(got);
        check_word("reset_notice", {2'd3, 3'd0, 29'd0}, got);

        for (t = 0; t < num_tests; t++) begin
            send_word(test_cmd[t]);
            receive_word(got);
            check_word(test_name[t], test_exp[t], got);
        end

        $display("Simulation completed successfully");
        $finish;
    end

    // Watchdog sized from the test count
    initial begin
        wait (load_done === 1'b1);
        repeat (RESET_CYCLES + (num_tests + 1) * TEST_CYCLES) @(posedge i_clk);
        stop_with_error("Timeout: the bridge stopped answering before all tests were done");
    end

endmodule

/* dbg_bus_top.f */
source/dbg_pkg.sv
source/cmd_assembler.sv
source/wb_master.sv
source/rsp_serializer.sv
source/wb_ram.sv
source/dbg_bus_top.sv
verif/dbg_bus_tb.sv

/* verif/dbg_bus_tests.txt */
# name  command  expected  (34-bit words as nine hex digits)
# subtype is the top hex digit, payload the lower eight
addr_auto_10      200000010  200000010
write_10          111111111  100000000
write_11          122222222  100000000
write_12          133333333  100000000
addr_back_10      200000010  200000010
read_10           000000000  011111111
read_11           000000000  022222222
read_12           000000000  033333333
addr_fixed_20     240000020  240000020
write_fixed_a     1aaaa0001  100000000
write_fixed_b     1bbbb0002  100000000
write_fixed_c     1cccc0003  100000000
read_fixed        000000000  0cccc0003
read_fixed_again  000000000  0cccc0003
addr_out_100      200000100  200000100
read_out_range    000000000  320000000
write_out_range   1deadbeef  320000000
addr_top          23fffffff  23fffffff
read_top          000000000  320000000
addr_back_11      200000011  200000011
read_after_err    000000000  022222222
addr_fixed_12     240000012  240000012
read_12_fixed     000000000  033333333
read_12_repeat    000000000  033333333
